// ==== dcache_macros.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// data cache sizes
// ~~~~~~~~~~~~~~~~~~~~
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// byte address and data word
`define DC_ADDR_W   32
`define DC_WORD_W   64
`define DC_STRB_W   8

// tag, index and offset fields of the address
`define DC_OFFSET_W 3
`define DC_INDEX_W  6
`define DC_TAG_W    23

// one word per set, two ways
`define DC_SETS     64
`define DC_WAYS     2

`endif

// ==== dcache_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// cache storage types
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

    // byte address as seen by the CPU
    typedef logic [`DC_ADDR_W-1:0]  addr_t;

    // set number and stored tag
    typedef logic [`DC_INDEX_W-1:0] index_t;
    typedef logic [`DC_TAG_W-1:0]   tag_t;

    // cached data word and its byte enables
    typedef logic [`DC_WORD_W-1:0]  word_t;
    typedef logic [`DC_STRB_W-1:0]  strb_t;

    // tag array payload, valid flag in the top bit
    typedef logic [`DC_TAG_W:0]     tag_entry_t;

    // way number
    typedef logic [$clog2(`DC_WAYS)-1:0] way_t;

endpackage

`default_nettype wire

// ==== mem_bus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// memory port kinds
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package mem_bus_pkg;

    // memory request kind, MEM_NONE when the port is idle
    typedef enum logic [1:0] {
        MEM_NONE      = 2'd0,
        MEM_WRITEBACK = 2'd1,
        MEM_REFILL    = 2'd2
    } mem_op_e;

    // controller states
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        LOOKUP    = 3'd1,
        HIT       = 3'd2,
        WRITEBACK = 3'd3,
        REFILL    = 3'd4
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== way_array.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// one cache way
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module way_array
    import dcache_pkg::*;
#(
    parameter type entry_t = word_t
) (
    input  wire logic   clk,
    input  wire logic   rst_n_i,
    input  wire index_t rd_index_i,
    input  wire logic   we_i,
    input  wire index_t wr_index_i,
    input  wire entry_t wr_entry_i,
    output entry_t      rd_entry_o
);

    entry_t mem_q [`DC_SETS];

    // storage write
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `DC_SETS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (we_i) begin
            mem_q[wr_index_i] <= wr_entry_i;
        end
    end

    // registered read, a write to the same entry shows up at once
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_entry_o <= '0;
        end else if (we_i && (wr_index_i == rd_index_i)) begin
            rd_entry_o <= wr_entry_i;
        end else begin
            rd_entry_o <= mem_q[rd_index_i];
        end
    end

endmodule

`default_nettype wire

// ==== set_lookup.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// set lookup
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module set_lookup
    import dcache_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n_i,
    input  wire addr_t addr_i,
    input  wire logic  tag_we_i,
    input  wire way_t  fill_way_i,
    input  wire logic  dirty_set_i,
    input  wire logic  dirty_clr_i,
    input  wire logic  touch_i,
    input  wire way_t  touch_way_i,
    output logic       hit_o,
    output way_t       hit_way_o,
    output way_t       victim_way_o,
    output logic       victim_dirty_o,
    output tag_t       victim_tag_o
);

    index_t              index;
    tag_t                req_tag;
    tag_entry_t          rd_entry [`DC_WAYS];
    logic [`DC_WAYS-1:0] way_valid;
    logic [`DC_WAYS-1:0] way_hit;
    logic [`DC_WAYS-1:0] dirty_q [`DC_SETS];
    way_t                mru_q [`DC_SETS];

    assign index   = addr_i[`DC_OFFSET_W +: `DC_INDEX_W];
    assign req_tag = addr_i[`DC_ADDR_W-1 -: `DC_TAG_W];

    // tag store and compare per way
    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        way_array #(
            .entry_t (tag_entry_t)
        ) u_tags (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .rd_index_i (index),
            .we_i       (tag_we_i && (fill_way_i == way_t'(w))),
            .wr_index_i (index),
            .wr_entry_i ({1'b1, req_tag}),
            .rd_entry_o (rd_entry[w])
        );

        assign way_valid[w] = rd_entry[w][`DC_TAG_W];
        assign way_hit[w]   = way_valid[w] && (rd_entry[w][`DC_TAG_W-1:0] == req_tag);
    end

    assign hit_o     = |way_hit;
    assign hit_way_o = way_t'(way_hit[1]);

    // empty way first, then the one not used last
    always_comb begin
        if (!way_valid[0]) begin
            victim_way_o = 1'b0;
        end else if (!way_valid[1]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = ~mru_q[index];
        end
    end

    assign victim_dirty_o = dirty_q[index][victim_way_o];
    assign victim_tag_o   = rd_entry[victim_way_o][`DC_TAG_W-1:0];

    // dirty and recency bits per set
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                dirty_q[s] <= '0;
                mru_q[s]   <= '0;
            end
        end else begin
            if (dirty_set_i) begin
                dirty_q[index][touch_way_i] <= 1'b1;
            end
            if (dirty_clr_i) begin
                dirty_q[index][fill_way_i] <= 1'b0;
            end
            if (touch_i) begin
                mru_q[index] <= touch_way_i;
            end
        end
    end

    // refills only go to a missing line, so a tag never sits in both ways
    a_single_hit: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0(way_hit));

endmodule

`default_nettype wire

// ==== cache_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// cache controller
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
    import dcache_pkg::*, mem_bus_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n_i,
    input  wire logic req_i,
    input  wire logic we_i,
    input  wire logic hit_i,
    input  wire way_t hit_way_i,
    input  wire way_t victim_way_i,
    input  wire logic victim_dirty_i,
    input  wire logic mem_ack_i,
    output logic      ack_o,
    output mem_op_e   mem_op_o,
    output logic      tag_we_o,
    output way_t      fill_way_o,
    output logic      dirty_set_o,
    output logic      dirty_clr_o,
    output logic      touch_o,
    output way_t      touch_way_o,
    output logic      refill_we_o,
    output logic      cpu_we_o,
    output way_t      sel_way_o
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        acked_q;
    logic        mem_phase;
    logic        ack_first;
    logic        hit_leave;

    assign mem_phase = (state_q == WRITEBACK) || (state_q == REFILL);
    // first cycle of the memory ack
    assign ack_first = mem_phase && mem_ack_i && !acked_q;
    // access retires once the CPU drops req
    assign hit_leave = (state_q == HIT) && !req_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit_i) begin
                    state_d = HIT;
                end else if (victim_dirty_i) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL;
                end
            end
            HIT: begin
                if (!req_i) begin
                    state_d = IDLE;
                end
            end
            // wait for the ack to fall before moving on
            WRITEBACK: begin
                if (acked_q && !mem_ack_i) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (acked_q && !mem_ack_i) begin
                    state_d = LOOKUP;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            acked_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_d != state_q) begin
                acked_q <= 1'b0;
            end else if (ack_first) begin
                acked_q <= 1'b1;
            end
        end
    end

    // request held until memory answers
    always_comb begin
        if ((state_q == WRITEBACK) && !acked_q) begin
            mem_op_o = MEM_WRITEBACK;
        end else if ((state_q == REFILL) && !acked_q) begin
            mem_op_o = MEM_REFILL;
        end else begin
            mem_op_o = MEM_NONE;
        end
    end

    assign ack_o = (state_q == HIT);

    // refill data is valid with the ack
    assign refill_we_o = ack_first && (state_q == REFILL);
    assign tag_we_o    = ack_first && (state_q == REFILL);
    assign dirty_clr_o = ack_first && (state_q == WRITEBACK);
    assign fill_way_o  = victim_way_i;

    assign cpu_we_o    = hit_leave && we_i;
    assign dirty_set_o = hit_leave && we_i;
    assign touch_o     = hit_leave;
    assign touch_way_o = hit_way_i;

    assign sel_way_o = mem_phase ? victim_way_i : hit_way_i;

    a_mem_op_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        ((mem_op_o != MEM_NONE) && !mem_ack_i) |=> (mem_op_o == $past(mem_op_o)));

    // ack only while the lookup still reports a hit
    a_ack_on_hit: assert property (@(posedge clk) disable iff (!rst_n_i)
        ack_o |-> hit_i);

endmodule

`default_nettype wire

// ==== data_path.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// cache data path
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module data_path
    import dcache_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_n_i,
    input  wire index_t index_i,
    input  wire way_t   sel_way_i,
    input  wire logic   refill_we_i,
    input  wire word_t  refill_data_i,
    input  wire logic   cpu_we_i,
    input  wire word_t  wdata_i,
    input  wire strb_t  strb_i,
    output word_t       rdata_o,
    output word_t       victim_data_o
);

    localparam int BYTE_W = `DC_WORD_W / `DC_STRB_W;

    word_t way_word [`DC_WAYS];
    word_t cur_word;
    word_t merged;
    word_t wr_word;

    assign cur_word = way_word[sel_way_i];

    // strobed bytes from the CPU, the rest kept
    always_comb begin
        merged = cur_word;
        for (int b = 0; b < `DC_STRB_W; b++) begin
            if (strb_i[b]) begin
                merged[b*BYTE_W +: BYTE_W] = wdata_i[b*BYTE_W +: BYTE_W];
            end
        end
    end

    assign wr_word = refill_we_i ? refill_data_i : merged;

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        way_array #(
            .entry_t (word_t)
        ) u_data (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .rd_index_i (index_i),
            .we_i       ((refill_we_i || cpu_we_i) && (sel_way_i == way_t'(w))),
            .wr_index_i (index_i),
            .wr_entry_i (wr_word),
            .rd_entry_o (way_word[w])
        );
    end

    // same word serves reads and write-backs
    assign rdata_o       = cur_word;
    assign victim_data_o = cur_word;

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// data cache top
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_top
    import dcache_pkg::*, mem_bus_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n_i,
    input  wire logic  req_i,
    input  wire logic  we_i,
    input  wire addr_t addr_i,
    input  wire word_t wdata_i,
    input  wire strb_t strb_i,
    output logic       ack_o,
    output word_t      rdata_o,
    output mem_op_e    mem_op_o,
    output addr_t      mem_addr_o,
    output word_t      mem_wdata_o,
    input  wire logic  mem_ack_i,
    input  wire word_t mem_rdata_i
);

    index_t index;
    tag_t   line_tag;
    tag_t   victim_tag;
    logic   hit;
    logic   victim_dirty;
    logic   tag_we;
    logic   dirty_set;
    logic   dirty_clr;
    logic   touch;
    logic   refill_we;
    logic   cpu_we;
    way_t   hit_way;
    way_t   victim_way;
    way_t   fill_way;
    way_t   touch_way;
    way_t   sel_way;

    assign index = addr_i[`DC_OFFSET_W +: `DC_INDEX_W];

    // write-back goes to the victim's line, refill to the requested one
    assign line_tag   = (mem_op_o == MEM_WRITEBACK) ? victim_tag
                                                    : addr_i[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign mem_addr_o = {line_tag, index, {`DC_OFFSET_W{1'b0}}};

    set_lookup u_lookup (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .addr_i         (addr_i),
        .tag_we_i       (tag_we),
        .fill_way_i     (fill_way),
        .dirty_set_i    (dirty_set),
        .dirty_clr_i    (dirty_clr),
        .touch_i        (touch),
        .touch_way_i    (touch_way),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    cache_ctrl u_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .req_i          (req_i),
        .we_i           (we_i),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .mem_ack_i      (mem_ack_i),
        .ack_o          (ack_o),
        .mem_op_o       (mem_op_o),
        .tag_we_o       (tag_we),
        .fill_way_o     (fill_way),
        .dirty_set_o    (dirty_set),
        .dirty_clr_o    (dirty_clr),
        .touch_o        (touch),
        .touch_way_o    (touch_way),
        .refill_we_o    (refill_we),
        .cpu_we_o       (cpu_we),
        .sel_way_o      (sel_way)
    );

    data_path u_data (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .index_i       (index),
        .sel_way_i     (sel_way),
        .refill_we_i   (refill_we),
        .refill_data_i (mem_rdata_i),
        .cpu_we_i      (cpu_we),
        .wdata_i       (wdata_i),
        .strb_i        (strb_i),
        .rdata_o       (rdata_o),
        .victim_data_o (mem_wdata_o)
    );

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// backing memory model
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model
    import dcache_pkg::*, mem_bus_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n_i,
    input  wire logic [1:0] delay_i,
    input  wire mem_op_e mem_op_i,
    input  wire addr_t   mem_addr_i,
    input  wire word_t   mem_wdata_i,
    output logic         mem_ack_o,
    output word_t        mem_rdata_o,
    output int           wb_cnt_o,
    output addr_t        wb_addr_o,
    output word_t        wb_data_o
);

    logic       ack_q = 1'b0;
    word_t      rdata_q = '0;
    logic       busy_q = 1'b0;
    logic [1:0] wait_q = 2'd0;

    assign mem_ack_o   = ack_q;
    assign mem_rdata_o = rdata_q;

    always @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q     <= 1'b0;
            rdata_q   <= '0;
            busy_q    <= 1'b0;
            wait_q    <= 2'd0;
            wb_cnt_o  <= 0;
            wb_addr_o <= '0;
            wb_data_o <= '0;
        end else if (ack_q) begin
            // ack stays up until the cache withdraws its request
            if (mem_op_i == MEM_NONE) begin
                ack_q <= 1'b0;
            end
        end else if (busy_q) begin
            if (wait_q == 2'd0) begin
                busy_q  <= 1'b0;
                ack_q   <= 1'b1;
                // line word is the address, inverted copy on top
                rdata_q <= {~mem_addr_i, mem_addr_i};
                if (mem_op_i == MEM_WRITEBACK) begin
                    wb_cnt_o  <= wb_cnt_o + 1;
                    wb_addr_o <= mem_addr_i;
                    wb_data_o <= mem_wdata_i;
                end
            end else begin
                wait_q <= wait_q - 2'd1;
            end
        end else if (mem_op_i != MEM_NONE) begin
            busy_q <= 1'b1;
            wait_q <= delay_i;
        end
    end

endmodule

`default_nettype wire

// ==== tb_dcache.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// data cache testbench
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module tb_dcache
    import dcache_pkg::*, mem_bus_pkg::*;
;

    // about 20 accesses of under 25 cycles each, plus reset, with wide margin
    localparam int MAX_CYCLES = 3000;

    logic       clk;
    logic       rst_n;
    logic       req;
    logic       we;
    addr_t      addr;
    word_t      wdata;
    strb_t      strb;
    logic       ack;
    word_t      rdata;
    mem_op_e    mem_op;
    addr_t      mem_addr;
    word_t      mem_wdata;
    logic       mem_ack;
    word_t      mem_rdata;
    logic [1:0] mem_delay;
    int         wb_cnt;
    addr_t      wb_addr;
    word_t      wb_data;

    logic [31:0] lfsr_q = 32'hfabb;
    int          err_cnt = 0;
    int          hs_err_cnt = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    int          cyc_cnt = 0;
    mem_op_e     op_log [$];
    addr_t       op_addr_log [$];

    dcache_top dut0 (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .req_i       (req),
        .we_i        (we),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .strb_i      (strb),
        .ack_o       (ack),
        .rdata_o     (rdata),
        .mem_op_o    (mem_op),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_ack_i   (mem_ack),
        .mem_rdata_i (mem_rdata)
    );

    tb_mem_model mem0 (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .delay_i     (mem_delay),
        .mem_op_i    (mem_op),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_ack_o   (mem_ack),
        .mem_rdata_o (mem_rdata),
        .wb_cnt_o    (wb_cnt),
        .wb_addr_o   (wb_addr),
        .wb_data_o   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[62:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    function automatic addr_t make_addr(input tag_t t, input index_t i,
                                        input logic [`DC_OFFSET_W-1:0] off);
        return {t, i, off};
    endfunction

    function automatic addr_t line_addr(input addr_t a);
        return {a[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
    endfunction

    // what memory holds for a line that was never written
    function automatic word_t refill_word(input addr_t a);
        return {~a, a};
    endfunction

    function automatic word_t apply_strobes(input word_t old, input word_t d, input strb_t s);
        word_t r;
        r = old;
        for (int b = 0; b < `DC_STRB_W; b++) begin
            if (s[b]) begin
                r[8*b +: 8] = d[8*b +: 8];
            end
        end
        return r;
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_ops(input int n, input mem_op_e op0, input addr_t ad0,
                             input mem_op_e op1, input addr_t ad1);
        check_val("memory op count", 64'(n), 64'(op_log.size()));
        if (op_log.size() == n) begin
            if (n > 0) begin
                check_val("mem_op_o", 64'(op0), 64'(op_log[0]));
                check_val("mem_addr_o", 64'(ad0), 64'(op_addr_log[0]));
            end
            if (n > 1) begin
                check_val("mem_op_o", 64'(op1), 64'(op_log[1]));
                check_val("mem_addr_o", 64'(ad1), 64'(op_addr_log[1]));
            end
        end
    endtask

    // one full cpu handshake, memory ops seen on the way are logged
    task automatic access(input logic wr, input addr_t a, input word_t d, input strb_t s,
                          output word_t rd, output int lat);
        mem_op_e prev;
        int      n;
        op_log.delete();
        op_addr_log.delete();
        prev      = MEM_NONE;
        n         = 0;
        req       <= 1'b1;
        we        <= wr;
        addr      <= a;
        wdata     <= d;
        strb      <= s;
        mem_delay <= 2'(rand_bits(2));
        do begin
            @(posedge clk);
            n++;
            if ((mem_op != MEM_NONE) && (mem_op != prev)) begin
                op_log.push_back(mem_op);
                op_addr_log.push_back(mem_addr);
            end
            prev = mem_op;
        end while (!ack);
        rd  = rdata;
        // cycles from the edge that samples req to the one that sees ack
        lat = n - 1;
        req <= 1'b0;
        do begin
            @(posedge clk);
        end while (ack);
    endtask

    task automatic finish_test(input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d wrong", name, errs);
        end
    endtask

    a_mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ((mem_op != MEM_NONE) && !mem_ack) |=>
            ((mem_op == $past(mem_op)) && (mem_addr == $past(mem_addr))))
        else begin
            $display("memory request changed before mem_ack_i rose");
            hs_err_cnt++;
        end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> req)
        else begin
            $display("ack_o rose while req_i was low");
            hs_err_cnt++;
        end

    always @(posedge clk) begin
        cyc_cnt++;
        if (cyc_cnt >= MAX_CYCLES) begin
            $display("run stopped by timeout after %0d cycles", cyc_cnt);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        word_t  rd;
        word_t  d1;
        word_t  d2;
        strb_t  s1;
        strb_t  s2;
        tag_t   t1;
        addr_t  a1;
        addr_t  a2;
        addr_t  a3;
        index_t idx;
        logic   wr_bit;
        int     lat;
        int     e0;
        int     wb0;
        rst_n     = 1'b0;
        req       = 1'b0;
        we        = 1'b0;
        addr      = '0;
        wdata     = '0;
        strb      = '0;
        mem_delay = 2'd0;

        // reset held for 10 edges, outputs quiet through the first idle cycle
        e0 = err_cnt;
        for (int c = 1; c <= 12; c++) begin
            @(posedge clk);
            if (c >= 2) begin
                check_val("ack_o", 64'd0, 64'(ack));
                check_val("mem_op_o", 64'(MEM_NONE), 64'(mem_op));
            end
            if (c == 10) begin
                rst_n <= 1'b1;
            end
        end
        finish_test("reset", err_cnt - e0);

        e0 = err_cnt;
        t1 = tag_t'(rand_bits(`DC_TAG_W));
        a1 = make_addr(t1, 6'd5, 3'd4);
        access(1'b0, a1, '0, '0, rd, lat);
        check_ops(1, MEM_REFILL, line_addr(a1), MEM_NONE, '0);
        check_val("rdata_o", refill_word(line_addr(a1)), rd);
        access(1'b0, a1, '0, '0, rd, lat);
        check_ops(0, MEM_NONE, '0, MEM_NONE, '0);
        check_val("rdata_o", refill_word(line_addr(a1)), rd);
        check_val("hit latency", 64'd2, 64'(lat));
        finish_test("read miss then hit", err_cnt - e0);

        e0 = err_cnt;
        d1 = rand_bits(64);
        s1 = strb_t'(rand_bits(`DC_STRB_W));
        access(1'b1, a1, d1, s1, rd, lat);
        check_ops(0, MEM_NONE, '0, MEM_NONE, '0);
        access(1'b0, a1, '0, '0, rd, lat);
        check_val("rdata_o", apply_strobes(refill_word(line_addr(a1)), d1, s1), rd);
        finish_test("write with strobes", err_cnt - e0);

        // two dirty lines in set 9, the third tag evicts the older one
        e0  = err_cnt;
        wb0 = wb_cnt;
        t1  = tag_t'(rand_bits(`DC_TAG_W));
        a1  = make_addr(t1, 6'd9, 3'd0);
        a2  = make_addr(t1 ^ 23'd1, 6'd9, 3'd2);
        a3  = make_addr(t1 ^ 23'd2, 6'd9, 3'd6);
        d1  = rand_bits(64);
        s1  = strb_t'(rand_bits(`DC_STRB_W));
        d2  = rand_bits(64);
        s2  = strb_t'(rand_bits(`DC_STRB_W));
        access(1'b1, a1, d1, s1, rd, lat);
        access(1'b1, a2, d2, s2, rd, lat);
        access(1'b0, a3, '0, '0, rd, lat);
        check_ops(2, MEM_WRITEBACK, line_addr(a1), MEM_REFILL, line_addr(a3));
        check_val("write-back count", 64'(wb0 + 1), 64'(wb_cnt));
        check_val("write-back address", 64'(line_addr(a1)), 64'(wb_addr));
        check_val("mem_wdata_o", apply_strobes(refill_word(line_addr(a1)), d1, s1), wb_data);
        check_val("rdata_o", refill_word(line_addr(a3)), rd);
        finish_test("dirty eviction", err_cnt - e0);

        e0  = err_cnt;
        wb0 = wb_cnt;
        t1  = tag_t'(rand_bits(`DC_TAG_W));
        for (int k = 0; k < 3; k++) begin
            a1 = make_addr(t1 ^ tag_t'(k), 6'd17, 3'd2);
            access(1'b0, a1, '0, '0, rd, lat);
            check_ops(1, MEM_REFILL, line_addr(a1), MEM_NONE, '0);
            check_val("rdata_o", refill_word(line_addr(a1)), rd);
        end
        check_val("write-back count", 64'(wb0), 64'(wb_cnt));
        finish_test("clean eviction", err_cnt - e0);

        // mixed traffic on a few sets and tags, checked by the handshake assertions
        for (int k = 0; k < 10; k++) begin
            idx    = 6'd40 + 6'(rand_bits(2));
            a1     = make_addr(tag_t'(rand_bits(2)), idx, 3'(rand_bits(3)));
            wr_bit = 1'(rand_bits(1));
            d1     = rand_bits(64);
            s1     = strb_t'(rand_bits(`DC_STRB_W));
            access(wr_bit, a1, d1, s1, rd, lat);
        end
        finish_test("handshake rules", hs_err_cnt);

        $display("tests %0d, with errors %0d, failed checks %0d",
                 tests_run, tests_bad, err_cnt + hs_err_cnt);
        if ((err_cnt + hs_err_cnt) == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
dcache_pkg.sv
mem_bus_pkg.sv
way_array.sv
set_lookup.sv
cache_ctrl.sv
data_path.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_dcache
FILELIST  = project.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
